//--- tb.f
design/mipsPkg.sv
design/registerFile.sv
design/controlDecoder.sv
design/instructionFetch.sv
design/instructionDecode.sv
design/executeStage.sv
design/memoryWriteback.sv
design/mipsCore.sv
dv/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mipsCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module mipsCoreTb -o mipsCoreSim
./obj_dir/mipsCoreSim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"

//--- dv/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

	logic clk;
	logic rst;
	logic [31:0] instrAddr;
	logic [31:0] instr;
	logic debugOn;
	logic [4:0] debugReadReg;
	logic [31:0] debugRegValue;

	// Program ROM and its length in words
	logic [31:0] rom [64];
	int progLen;
	// Reference model state
	logic [31:0] modelRegs [32];
	logic [31:0] modelMem [64];
	int errors;
	int checks;
	bit timedOut;
	integer seed;

	mipsCore i_dut (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instr(instr),
		.debugOn(debugOn),
		.debugReadReg(debugReadReg),
		.debugRegValue(debugRegValue)
	);

	always #2 clk = ~clk;

	// Nop past the end of the program
	always_comb
	begin
		if (instrAddr < 32'(4 * progLen))
			instr = rom[instrAddr[7:2]];
		else
			instr = '0;
	end

	////////////////////////////////////////
	// Encoders and program building
	////////////////////////////////////////
	function automatic logic [31:0] encR(input logic [5:0] fn, input int rd, input int rs,
		input int rt);
		return {mipsPkg::opRType, rs[4:0], rt[4:0], rd[4:0], 5'b0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input int rt, input int rs,
		input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [5:0] fnCode(input logic [2:0] kind);
		case (kind)
			3'd0: return mipsPkg::fnAdd;
			3'd1: return mipsPkg::fnSub;
			3'd2: return mipsPkg::fnAnd;
			3'd3: return mipsPkg::fnOr;
			default: return mipsPkg::fnSlt;
		endcase
	endfunction

	task automatic newProgram();
		for (int i = 0; i < 64; i++)
			rom[i] = '0;
		progLen = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		rom[progLen] = word;
		progLen++;
	endtask

	// Eight registers with loads and stores based on r0 to keep the address in range
	task automatic addRandomInstr();
		logic [31:0] r;
		r = $random(seed);
		case (r[2:0])
			3'd0, 3'd1, 3'd2, 3'd3, 3'd4:
				emit(encR(fnCode(r[2:0]), {29'b0, r[5:3]}, {29'b0, r[8:6]}, {29'b0, r[11:9]}));
			3'd5:
				emit(encI(mipsPkg::opAddi, {29'b0, r[5:3]}, {29'b0, r[8:6]},
					{{16{r[31]}}, r[31:16]}));
			3'd6:
				emit(encI(mipsPkg::opLw, {29'b0, r[5:3]}, 0, {24'b0, r[21:16], 2'b00}));
			default:
				emit(encI(mipsPkg::opSw, {29'b0, r[5:3]}, 0, {24'b0, r[21:16], 2'b00}));
		endcase
	endtask

	////////////////////////////////////////
	// Sequential reference model
	////////////////////////////////////////
	// Writes from instruction indices supLo..supHi are dropped
	task automatic runModel(input int supLo, input int supHi);
		int pc;
		int steps;
		int nextPc;
		logic [31:0] w;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] val;
		logic [4:0] dest;
		logic wrEn;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < 64; i++)
			modelMem[i] = '0;
		pc = 0;
		steps = 0;
		while (pc >= 0 && pc < progLen && steps < 1000)
		begin
			w = rom[pc];
			imm = {{16{w[15]}}, w[15:0]};
			a = modelRegs[w[25:21]];
			b = modelRegs[w[20:16]];
			addr = a + imm;
			dest = w[20:16];
			wrEn = 1'b0;
			val = '0;
			nextPc = pc + 1;
			case (w[31:26])
				mipsPkg::opRType:
				begin
					dest = w[15:11];
					wrEn = 1'b1;
					case (w[5:0])
						mipsPkg::fnAdd: val = a + b;
						mipsPkg::fnSub: val = a - b;
						mipsPkg::fnAnd: val = a & b;
						mipsPkg::fnOr: val = a | b;
						mipsPkg::fnSlt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wrEn = 1'b0;
					endcase
				end
				mipsPkg::opAddi:
				begin
					wrEn = 1'b1;
					val = a + imm;
				end
				mipsPkg::opLw:
				begin
					wrEn = 1'b1;
					val = modelMem[addr[7:2]];
				end
				mipsPkg::opSw: modelMem[addr[7:2]] = b;
				// Offset counted in words from the next instruction
				mipsPkg::opBeq:
				begin
					if (a == b)
						nextPc = pc + 1 + int'(imm);
				end
				default: wrEn = 1'b0;
			endcase
			if (wrEn && dest != 5'd0 && (pc < supLo || pc > supHi))
				modelRegs[dest] = val;
			pc = nextPc;
			steps++;
		end
	endtask

	////////////////////////////////////////
	// Run control and checks
	////////////////////////////////////////
	task automatic applyReset();
		@(posedge clk);
		#0.5;
		rst = 1'b1;
		debugOn = 1'b0;
		repeat (2) @(posedge clk);
		#0.5;
		rst = 1'b0;
	endtask

	task automatic waitForAddr(input int addr, input string name);
		int cycles;
		cycles = 0;
		while (instrAddr < 32'(addr) && cycles < 200)
		begin
			@(posedge clk);
			#0.5;
			cycles++;
		end
		if (instrAddr < 32'(addr))
		begin
			$display("Timeout in %s: fetch never reached address %0d within 200 cycles",
				name, addr);
			timedOut = 1'b1;
			errors++;
		end
	endtask

	// Debug port walk over the low registers
	task automatic checkRegs(input string name);
		for (int r = 0; r < 16; r++)
		begin
			@(posedge clk);
			#0.5;
			debugReadReg = 5'(r);
			#1;
			checks++;
			assert (debugRegValue == modelRegs[r])
			else
			begin
				$display("MISMATCH %s r%0d expected %h actual %h", name, r,
					modelRegs[r], debugRegValue);
				errors++;
			end
		end
	endtask

	// debugAddr below zero means no debug window
	task automatic runProgram(input string name, input int debugAddr, input int supLo,
		input int supHi);
		if (timedOut)
			return;
		runModel(supLo, supHi);
		applyReset();
		if (debugAddr >= 0)
		begin
			waitForAddr(debugAddr, name);
			if (!timedOut)
			begin
				debugOn = 1'b1;
				repeat (8) @(posedge clk);
				#0.5;
				debugOn = 1'b0;
			end
		end
		if (!timedOut)
			waitForAddr(4 * progLen, name);
		if (!timedOut)
		begin
			// Last write lands four edges after the halt fetch plus one stall
			repeat (5) @(posedge clk);
			checkRegs(name);
		end
	endtask

	initial
	begin
		seed = 32'h9299;
		clk = 1'b0;
		rst = 1'b1;
		debugOn = 1'b0;
		debugReadReg = '0;
		errors = 0;
		checks = 0;
		timedOut = 1'b0;
		newProgram();

		// Dependent chain over both forwarding paths and then write-through
		emit(encI(mipsPkg::opAddi, 1, 0, 5));
		emit(encI(mipsPkg::opAddi, 2, 1, 3));
		emit(encR(mipsPkg::fnAdd, 3, 1, 2));
		emit(encR(mipsPkg::fnSub, 4, 3, 1));
		emit(encR(mipsPkg::fnAnd, 5, 4, 2));
		emit(encR(mipsPkg::fnOr, 6, 5, 3));
		emit(encR(mipsPkg::fnSlt, 7, 4, 3));
		emit(encI(mipsPkg::opAddi, 8, 0, -2));
		emit(encR(mipsPkg::fnSlt, 9, 8, 1));
		emit(encI(mipsPkg::opAddi, 11, 0, 9));
		emit('0);
		emit('0);
		emit(encR(mipsPkg::fnAdd, 12, 11, 11));
		runProgram("dependentAlu", -1, -1, -1);

		// Load followed at once by its consumer
		newProgram();
		emit(encI(mipsPkg::opAddi, 1, 0, 40));
		emit(encI(mipsPkg::opSw, 1, 0, 8));
		emit(encI(mipsPkg::opLw, 2, 0, 8));
		emit(encR(mipsPkg::fnAdd, 3, 2, 2));
		emit(encI(mipsPkg::opLw, 4, 0, 8));
		emit(encI(mipsPkg::opAddi, 5, 4, 1));
		runProgram("loadUse", -1, -1, -1);

		// Store then load with r0 writes ignored
		newProgram();
		emit(encI(mipsPkg::opAddi, 1, 0, 32'h1234));
		emit(encI(mipsPkg::opSw, 1, 0, 12));
		emit(encI(mipsPkg::opLw, 2, 0, 12));
		emit(encI(mipsPkg::opAddi, 0, 0, 5));
		emit(encR(mipsPkg::fnAdd, 0, 1, 1));
		emit(encR(mipsPkg::fnOr, 3, 0, 2));
		runProgram("storeLoadZero", -1, -1, -1);

		// Taken beq skips two and not-taken beq falls through
		newProgram();
		emit(encI(mipsPkg::opAddi, 1, 0, 7));
		emit(encI(mipsPkg::opAddi, 2, 0, 7));
		emit(encI(mipsPkg::opBeq, 2, 1, 2));
		emit(encI(mipsPkg::opAddi, 3, 0, 1));
		emit(encI(mipsPkg::opAddi, 4, 0, 2));
		emit(encI(mipsPkg::opAddi, 5, 0, 3));
		emit(encI(mipsPkg::opBeq, 5, 1, 2));
		emit(encI(mipsPkg::opAddi, 6, 0, 4));
		emit(encI(mipsPkg::opAddi, 7, 0, 5));
		runProgram("branch", -1, -1, -1);

		// Indices 9 to 11 retire inside the debug window
		newProgram();
		emit(encI(mipsPkg::opAddi, 4, 0, 11));
		emit(encI(mipsPkg::opAddi, 5, 0, 22));
		emit(encI(mipsPkg::opAddi, 6, 0, 33));
		repeat (6) emit('0);
		emit(encI(mipsPkg::opAddi, 4, 0, 44));
		emit(encI(mipsPkg::opAddi, 5, 0, 55));
		emit(encI(mipsPkg::opAddi, 6, 0, 66));
		repeat (6) emit('0);
		emit(encR(mipsPkg::fnAdd, 7, 4, 5));
		runProgram("debugBlock", 36, 9, 11);

		for (int p = 0; p < 20; p++)
		begin
			newProgram();
			repeat (12) addRandomInstr();
			runProgram($sformatf("random%0d", p), -1, -1, -1);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !timedOut)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
	input logic clk,
	input logic rst,
	output logic [mipsPkg::dataWidth-1:0] instrAddr,
	input logic [mipsPkg::dataWidth-1:0] instr,
	input logic debugOn,
	input logic [mipsPkg::regAddrWidth-1:0] debugReadReg,
	output logic [mipsPkg::dataWidth-1:0] debugRegValue
);

	// Stage registers and feedback
	mipsPkg::ifIdT ifId;
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWb;
	mipsPkg::wbT wb;
	logic stall;
	logic branchTaken;
	logic [mipsPkg::dataWidth-1:0] branchTarget;

	instructionFetch i_fetch (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.instr(instr),
		.instrAddr(instrAddr),
		.ifId(ifId)
	);

	instructionDecode i_decode (
		.clk(clk),
		.rst(rst),
		.ifId(ifId),
		.wb(wb),
		.branchTaken(branchTaken),
		.debugOn(debugOn),
		.debugReadReg(debugReadReg),
		.debugRegValue(debugRegValue),
		.stall(stall),
		.idEx(idEx)
	);

	// Execute sees both forwarding sources
	executeStage i_execute (
		.clk(clk),
		.rst(rst),
		.idEx(idEx),
		.wb(wb),
		.exMemFwd(exMem),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	memoryWriteback i_memWb (
		.clk(clk),
		.rst(rst),
		.exMem(exMem),
		.memWb(memWb),
		.wb(wb)
	);

endmodule

//--- design/memoryWriteback.sv
`timescale 1ns/1ps

module memoryWriteback (
	input logic clk,
	input logic rst,
	input mipsPkg::exMemT exMem,
	output mipsPkg::memWbT memWb,
	output mipsPkg::wbT wb
);

	logic [mipsPkg::dataWidth-1:0] dmem [mipsPkg::dmemDepth];
	logic [$clog2(mipsPkg::dmemDepth)-1:0] memIndex;
	logic [mipsPkg::dataWidth-1:0] loadData;

	// Word index from the byte address
	assign memIndex = exMem.aluResult[2 +: $clog2(mipsPkg::dmemDepth)];
	assign loadData = exMem.ctrl.memRead ? dmem[memIndex] : '0;

	////////////////////////////////////////
	// Data memory
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < mipsPkg::dmemDepth; i++)
				dmem[i] <= '0;
		end
		else if (exMem.ctrl.memWrite)
			dmem[memIndex] <= exMem.storeData;
	end

	// MEM/WB register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
		end
		else
		begin
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.memToReg <= exMem.ctrl.memToReg;
		end
		memWb.aluResult <= exMem.aluResult;
		memWb.loadData <= loadData;
		memWb.destReg <= exMem.destReg;
	end

	// Writeback select
	always_comb
	begin
		wb.en = memWb.regWrite;
		wb.addr = memWb.destReg;
		wb.data = memWb.memToReg ? memWb.loadData : memWb.aluResult;
	end

endmodule

//--- design/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rst,
	input mipsPkg::idExT idEx,
	input mipsPkg::wbT wb,
	output mipsPkg::exMemT exMemFwd,
	output logic branchTaken,
	output logic [mipsPkg::dataWidth-1:0] branchTarget
);

	logic [mipsPkg::dataWidth-1:0] opA;
	logic [mipsPkg::dataWidth-1:0] opB;
	logic [mipsPkg::dataWidth-1:0] srcB;
	logic [mipsPkg::dataWidth-1:0] aluResult;

	// Youngest producer first, then writeback, then the file value
	function automatic logic [mipsPkg::dataWidth-1:0] forward(
		input logic [mipsPkg::regAddrWidth-1:0] src,
		input logic [mipsPkg::dataWidth-1:0] fileVal);
		if (exMemFwd.ctrl.regWrite && (exMemFwd.destReg != '0) && (exMemFwd.destReg == src))
			return exMemFwd.aluResult;
		else if (wb.en && (wb.addr != '0) && (wb.addr == src))
			return wb.data;
		else
			return fileVal;
	endfunction

	////////////////////////////////////////
	// Operands and ALU
	////////////////////////////////////////
	always_comb
	begin
		opA = forward(idEx.rs, idEx.regA);
		opB = forward(idEx.rt, idEx.regB);
		srcB = idEx.ctrl.aluSrcImm ? idEx.immExt : opB;
		case (idEx.ctrl.aluOp)
			mipsPkg::aluAdd: aluResult = opA + srcB;
			mipsPkg::aluSub: aluResult = opA - srcB;
			mipsPkg::aluAnd: aluResult = opA & srcB;
			mipsPkg::aluOr: aluResult = opA | srcB;
			// Signed compare
			mipsPkg::aluSlt: aluResult = {31'b0, $signed(opA) < $signed(srcB)};
			default: aluResult = '0;
		endcase
	end

	// beq decision, one cycle since the next idEx is a bubble
	assign branchTaken = idEx.ctrl.branch && (opA == opB);
	assign branchTarget = idEx.pcPlus4 + {idEx.immExt[29:0], 2'b00};

	// EX/MEM register
	always_ff @(posedge clk)
	begin
		if (rst || branchTaken)
			exMemFwd.ctrl <= '0;
		else
			exMemFwd.ctrl <= idEx.ctrl;
		exMemFwd.aluResult <= aluResult;
		// Store data after forwarding
		exMemFwd.storeData <= opB;
		exMemFwd.destReg <= idEx.destReg;
	end

endmodule

//--- design/instructionDecode.sv
`timescale 1ns/1ps

module instructionDecode (
	input logic clk,
	input logic rst,
	input mipsPkg::ifIdT ifId,
	input mipsPkg::wbT wb,
	input logic branchTaken,
	input logic debugOn,
	input logic [mipsPkg::regAddrWidth-1:0] debugReadReg,
	output logic [mipsPkg::dataWidth-1:0] debugRegValue,
	output logic stall,
	output mipsPkg::idExT idEx
);

	logic [mipsPkg::regAddrWidth-1:0] rs;
	logic [mipsPkg::regAddrWidth-1:0] rt;
	logic [mipsPkg::regAddrWidth-1:0] rd;
	logic [15:0] imm;
	logic [mipsPkg::dataWidth-1:0] regA;
	logic [mipsPkg::dataWidth-1:0] regB;
	logic regWriteEn;
	mipsPkg::ctrlT ctrl;

	// Instruction fields
	assign rs = ifId.instruction[25:21];
	assign rt = ifId.instruction[20:16];
	assign rd = ifId.instruction[15:11];
	assign imm = ifId.instruction[15:0];

	////////////////////////////////////////
	// Hazard detection
	////////////////////////////////////////
	// Load now in execute feeding the instruction in decode
	assign stall = idEx.ctrl.memRead && (idEx.destReg != '0)
		&& ((idEx.destReg == rs) || (idEx.destReg == rt));

	// Writes are dropped while debug is on
	assign regWriteEn = wb.en && !debugOn;

	controlDecoder i_controlDecoder (
		.instruction(ifId.instruction),
		.ctrl(ctrl)
	);

	registerFile i_registerFile (
		.clk(clk),
		.rst(rst),
		.wrEn(regWriteEn),
		.wrAddr(wb.addr),
		.wrData(wb.data),
		.rdAddrA(rs),
		.rdAddrB(rt),
		.rdAddrDebug(debugReadReg),
		.rdDataA(regA),
		.rdDataB(regB),
		.rdDataDebug(debugRegValue)
	);

	////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		// Bubble on reset, load-use stall or flush
		if (rst || stall || branchTaken)
			idEx.ctrl <= '0;
		else
			idEx.ctrl <= ctrl;
		idEx.pcPlus4 <= ifId.pcPlus4;
		idEx.regA <= regA;
		idEx.regB <= regB;
		// Sign extension
		idEx.immExt <= {{16{imm[15]}}, imm};
		idEx.rs <= rs;
		idEx.rt <= rt;
		idEx.destReg <= ctrl.regDstRd ? rd : rt;
	end

endmodule

//--- design/instructionFetch.sv
`timescale 1ns/1ps

module instructionFetch (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic branchTaken,
	input logic [mipsPkg::dataWidth-1:0] branchTarget,
	input logic [mipsPkg::dataWidth-1:0] instr,
	output logic [mipsPkg::dataWidth-1:0] instrAddr,
	output mipsPkg::ifIdT ifId
);

	logic [mipsPkg::dataWidth-1:0] pc;
	logic [mipsPkg::dataWidth-1:0] pcPlus4;

	assign pcPlus4 = pc + 32'd4;
	// Instruction port is read in the same cycle
	assign instrAddr = pc;

	// PC and IF/ID
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			ifId <= '0;
		end
		// Branch wins over a stall, the fetched word becomes a nop
		else if (branchTaken)
		begin
			pc <= branchTarget;
			ifId <= '0;
		end
		else if (!stall)
		begin
			pc <= pcPlus4;
			ifId.pcPlus4 <= pcPlus4;
			ifId.instruction <= instr;
		end
	end

endmodule

//--- design/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
	input logic [mipsPkg::dataWidth-1:0] instruction,
	output mipsPkg::ctrlT ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instruction[31:26];
	assign funct = instruction[5:0];

	always_comb
	begin
		// Default is a nop
		ctrl = '0;
		case (opcode)
			mipsPkg::opRType:
			begin
				ctrl.regDstRd = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
					// Unknown function, also the all-zero nop word
					default: ctrl = '0;
				endcase
			end
			mipsPkg::opAddi:
			begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// Address is base plus offset, add is the zero aluOp
			mipsPkg::opLw:
			begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::opSw:
			begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsPkg::opBeq:
			begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = mipsPkg::aluSub;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input logic [mipsPkg::regAddrWidth-1:0] wrAddr,
	input logic [mipsPkg::dataWidth-1:0] wrData,
	input logic [mipsPkg::regAddrWidth-1:0] rdAddrA,
	input logic [mipsPkg::regAddrWidth-1:0] rdAddrB,
	input logic [mipsPkg::regAddrWidth-1:0] rdAddrDebug,
	output logic [mipsPkg::dataWidth-1:0] rdDataA,
	output logic [mipsPkg::dataWidth-1:0] rdDataB,
	output logic [mipsPkg::dataWidth-1:0] rdDataDebug
);

	logic [mipsPkg::dataWidth-1:0] regs [2**mipsPkg::regAddrWidth];

	// Register zero is hardwired, a same-cycle write passes straight through
	function automatic logic [mipsPkg::dataWidth-1:0] readReg(
		input logic [mipsPkg::regAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wrEn && (wrAddr == addr))
			return wrData;
		else
			return regs[addr];
	endfunction

	// Three independent read ports
	always_comb
	begin
		rdDataA = readReg(rdAddrA);
		rdDataB = readReg(rdAddrB);
		rdDataDebug = readReg(rdAddrDebug);
	end

	// Write port, entry zero never written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2**mipsPkg::regAddrWidth; i++)
				regs[i] <= '0;
		end
		else if (wrEn && (wrAddr != '0))
			regs[wrAddr] <= wrData;
	end

endmodule

//--- design/mipsPkg.sv
package mipsPkg;

	////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	// Data memory depth in words
	localparam int dmemDepth = 64;

	// Primary opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;

	// R-type function field
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

	////////////////////////////////////////
	// Pipeline register payloads
	////////////////////////////////////////
	// All zero means a bubble
	typedef struct packed {
		aluOpT aluOp;
		logic aluSrcImm;
		logic regDstRd;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
		logic branch;
	} ctrlT;

	typedef struct packed {
		logic [dataWidth-1:0] pcPlus4;
		logic [dataWidth-1:0] instruction;
	} ifIdT;

	// destReg already resolved between rt and rd
	typedef struct packed {
		ctrlT ctrl;
		logic [dataWidth-1:0] pcPlus4;
		logic [dataWidth-1:0] regA;
		logic [dataWidth-1:0] regB;
		logic [dataWidth-1:0] immExt;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] destReg;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] storeData;
		logic [regAddrWidth-1:0] destReg;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [dataWidth-1:0] aluResult;
		logic [dataWidth-1:0] loadData;
		logic [regAddrWidth-1:0] destReg;
	} memWbT;

	// Register write back to decode, also the late forwarding source
	typedef struct packed {
		logic en;
		logic [regAddrWidth-1:0] addr;
		logic [dataWidth-1:0] data;
	} wbT;

endpackage
